//--- common/csr_params.svh
// CSR addresses, reset values, write masks and identity constants
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

////////////////////////////////////////
// Trap and machine information CSRs
////////////////////////////////////////

`define CSR_ADDR_MSTATUS        12'h300
`define CSR_ADDR_MISA           12'h301
`define CSR_ADDR_MIE            12'h304
`define CSR_ADDR_MTVEC          12'h305
`define CSR_ADDR_MSCRATCH       12'h340
`define CSR_ADDR_MEPC           12'h341
`define CSR_ADDR_MCAUSE         12'h342
`define CSR_ADDR_MIP            12'h344
`define CSR_ADDR_MVENDORID      12'hF11
`define CSR_ADDR_MARCHID        12'hF12

////////////////////////////////////////
// Performance monitor CSRs
////////////////////////////////////////

`define CSR_ADDR_MCOUNTINHIBIT  12'h320
`define CSR_ADDR_MHPMEVENT3     12'h323
`define CSR_ADDR_MCYCLE         12'hB00   // Low halves
`define CSR_ADDR_MINSTRET       12'hB02
`define CSR_ADDR_MHPMCOUNTER3   12'hB03
`define CSR_ADDR_MCYCLEH        12'hB80   // High halves
`define CSR_ADDR_MINSTRETH      12'hB82
`define CSR_ADDR_MHPMCOUNTER3H  12'hB83

// Identity values
`define MISA_VALUE              32'h40001104  // RV32 with I, M, C
`define MVENDORID_VALUE         32'h00000000  // Non-commercial
`define MARCHID_VALUE           32'h00000014

// mstatus fields kept in this core
`define MSTATUS_MIE_BIT         3
`define MSTATUS_MPIE_BIT        7
`define MSTATUS_MPP_M           2'b11         // Bits 12:11, M-mode only

// Masks and reset values
`define MIE_WRITE_MASK          32'hFFFF0888  // Fast irqs plus MSI, MTI, MEI
`define MTVEC_RESET_VAL         32'h00000001  // Vectored mode, base 0
`define MCOUNTINHIBIT_RESET_VAL 32'h0000000D  // All counters stopped
`define MCOUNTINHIBIT_MASK      32'h0000000D  // CY, IR and HPM3 only

// Event line indices for mhpmevent3
`define HPM_EVENT_CYCLE         0
`define HPM_EVENT_INSTRET       1
`define HPM_EVENT_LOAD          2
`define HPM_EVENT_STORE         3
`define HPM_EVENT_BRANCH        4

`endif

//--- common/csr_pkg.sv
// Shared CSR data, address, counter and operation types
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////
  // Data path widths
  ////////////////////////////////////////

  typedef logic [31:0] csr_word_t;    // One CSR data word
  typedef logic [11:0] csr_addr_t;    // CSR number from the instruction
  typedef logic [63:0] hpm_count_t;   // Full counter value, both halves
  typedef logic [4:0]  hpm_event_t;   // One bit per countable event

  ////////////////////////////////////////
  // Access operations
  ////////////////////////////////////////

  // Encoding follows funct3[1:0] of the CSR instructions
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,   // csrr, no write side effect
    CSR_OP_WRITE = 2'b01,   // csrrw
    CSR_OP_SET   = 2'b10,   // csrrs
    CSR_OP_CLEAR = 2'b11    // csrrc
  } csr_op_e;

endpackage

`default_nettype wire

//--- verilog/csr_access_unit.sv
// CSR read merge and read-modify-write value for set and clear
`timescale 1ns/1ns
`default_nettype none

module csr_access_unit import csr_pkg::*; (
  input  wire logic      csr_access_i,
  input  wire csr_op_e   csr_op_i,
  input  wire csr_word_t csr_wdata_i,
  // Bank results
  input  wire logic      trap_hit_i,
  input  wire csr_word_t trap_rdata_i,
  input  wire logic      hpm_hit_i,
  input  wire csr_word_t hpm_rdata_i,
  // To the core and the banks
  output csr_word_t      csr_rdata_o,
  output logic           csr_we_o,
  output csr_word_t      csr_new_wdata_o
);

  csr_word_t bank_rdata;   // Current value of the addressed CSR
  logic      any_hit;

  ////////////////////////////////////////
  // Read merge
  ////////////////////////////////////////

  assign any_hit = trap_hit_i | hpm_hit_i;

  always_comb begin
    bank_rdata = '0;                      // Unmapped reads 0
    if (trap_hit_i)     bank_rdata = trap_rdata_i;
    else if (hpm_hit_i) bank_rdata = hpm_rdata_i;
  end

  assign csr_rdata_o = csr_access_i ? bank_rdata : '0;

  ////////////////////////////////////////
  // Write value
  ////////////////////////////////////////

  always_comb begin
    case (csr_op_i)
      CSR_OP_WRITE: csr_new_wdata_o = csr_wdata_i;
      CSR_OP_SET:   csr_new_wdata_o = bank_rdata | csr_wdata_i;
      CSR_OP_CLEAR: csr_new_wdata_o = bank_rdata & ~csr_wdata_i;
      default:      csr_new_wdata_o = bank_rdata;     // Read leaves value
    endcase
  end

  // No write for plain reads or addresses nobody owns
  assign csr_we_o = csr_access_i && (csr_op_i != CSR_OP_READ) && any_hit;

  // Bank address maps must not overlap
  always_comb begin
    if (csr_access_i) begin
      assert (!(trap_hit_i && hpm_hit_i))
        else $error("both CSR banks decode the same address");
    end
  end

endmodule

`default_nettype wire

//--- trap/machine_trap_csrs.sv
// Machine trap CSRs, identity CSRs, trap entry and mret update
`timescale 1ns/1ns
`default_nettype none
`include "csr_params.svh"

module machine_trap_csrs import csr_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst_n,
  // Software access, already qualified by the access unit
  input  wire csr_addr_t   csr_addr_i,
  input  wire logic        csr_we_i,
  input  wire csr_word_t   csr_wdata_i,
  // Trap controller
  input  wire logic        trap_save_i,
  input  wire logic [5:0]  trap_cause_i,  // Bit 5 flags an interrupt
  input  wire csr_word_t   trap_pc_i,
  input  wire logic        mret_i,
  input  wire csr_word_t   mip_i,
  // Read side
  output csr_word_t        rdata_o,
  output logic             hit_o,
  // To the core
  output logic [23:0]      mtvec_addr_o,
  output logic [1:0]       mtvec_mode_o,
  output csr_word_t        mepc_o,
  output csr_word_t        mie_o,
  output logic             m_irq_enable_o
);

  localparam csr_word_t MTVEC_RST = `MTVEC_RESET_VAL;

  logic        mstatus_mie_q;       // Global irq enable
  logic        mstatus_mpie_q;      // Enable before last trap
  csr_word_t   mie_q;
  logic [23:0] mtvec_addr_q;        // Base, 256 byte aligned
  logic        mtvec_mode_q;        // Low mode bit, 1 = vectored
  csr_word_t   mscratch_q;
  csr_word_t   mepc_q;
  csr_word_t   mcause_q;
  csr_word_t   mstatus_rd;

  // mstatus as seen by software
  always_comb begin
    mstatus_rd                     = '0;
    mstatus_rd[12:11]              = `MSTATUS_MPP_M;   // Always M
    mstatus_rd[`MSTATUS_MPIE_BIT]  = mstatus_mpie_q;
    mstatus_rd[`MSTATUS_MIE_BIT]   = mstatus_mie_q;
  end

  ////////////////////////////////////////
  // Read decode
  ////////////////////////////////////////

  always_comb begin
    hit_o   = 1'b1;
    rdata_o = '0;
    case (csr_addr_i)
      `CSR_ADDR_MSTATUS:   rdata_o = mstatus_rd;
      `CSR_ADDR_MISA:      rdata_o = `MISA_VALUE;
      `CSR_ADDR_MIE:       rdata_o = mie_q;
      `CSR_ADDR_MTVEC:     rdata_o = {mtvec_addr_q, 7'b0, mtvec_mode_q};
      `CSR_ADDR_MSCRATCH:  rdata_o = mscratch_q;
      `CSR_ADDR_MEPC:      rdata_o = mepc_q;
      `CSR_ADDR_MCAUSE:    rdata_o = mcause_q;
      `CSR_ADDR_MIP:       rdata_o = mip_i;           // Live pending lines
      `CSR_ADDR_MVENDORID: rdata_o = `MVENDORID_VALUE;
      `CSR_ADDR_MARCHID:   rdata_o = `MARCHID_VALUE;
      default:             hit_o   = 1'b0;            // Not in this bank
    endcase
  end

  ////////////////////////////////////////
  // Register updates
  ////////////////////////////////////////

  // Per register write strobes, read only CSRs have none
  logic mstatus_we, mie_we, mtvec_we, mscratch_we, mepc_we, mcause_we;

  assign mstatus_we  = csr_we_i && (csr_addr_i == `CSR_ADDR_MSTATUS);
  assign mie_we      = csr_we_i && (csr_addr_i == `CSR_ADDR_MIE);
  assign mtvec_we    = csr_we_i && (csr_addr_i == `CSR_ADDR_MTVEC);
  assign mscratch_we = csr_we_i && (csr_addr_i == `CSR_ADDR_MSCRATCH);
  assign mepc_we     = csr_we_i && (csr_addr_i == `CSR_ADDR_MEPC);
  assign mcause_we   = csr_we_i && (csr_addr_i == `CSR_ADDR_MCAUSE);

  // mstatus: trap entry, then mret, then software
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
    end else if (trap_save_i) begin
      mstatus_mpie_q <= mstatus_mie_q;   // Stack the enable
      mstatus_mie_q  <= 1'b0;
    end else if (mret_i) begin
      mstatus_mie_q  <= mstatus_mpie_q;  // Unstack
      mstatus_mpie_q <= 1'b1;
    end else if (mstatus_we) begin
      mstatus_mie_q  <= csr_wdata_i[`MSTATUS_MIE_BIT];
      mstatus_mpie_q <= csr_wdata_i[`MSTATUS_MPIE_BIT];
    end
  end

  // mepc and mcause: trap entry beats software
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mepc_q   <= '0;
      mcause_q <= '0;
    end else if (trap_save_i) begin
      mepc_q   <= trap_pc_i;
      mcause_q <= {trap_cause_i[5], 26'b0, trap_cause_i[4:0]};
    end else begin
      if (mepc_we) begin
        mepc_q <= {csr_wdata_i[31:1], 1'b0};          // Halfword aligned
      end
      if (mcause_we) begin
        mcause_q <= {csr_wdata_i[31], 26'b0, csr_wdata_i[4:0]};
      end
    end
  end

  // Software only registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q        <= '0;
      mtvec_addr_q <= MTVEC_RST[31:8];
      mtvec_mode_q <= MTVEC_RST[0];
      mscratch_q   <= '0;
    end else begin
      if (mie_we) mie_q <= csr_wdata_i & `MIE_WRITE_MASK;
      if (mtvec_we) begin
        mtvec_addr_q <= csr_wdata_i[31:8];
        mtvec_mode_q <= csr_wdata_i[0];               // Direct or vectored
      end
      if (mscratch_we) mscratch_q <= csr_wdata_i;
    end
  end

  assign mtvec_addr_o   = mtvec_addr_q;
  assign mtvec_mode_o   = {1'b0, mtvec_mode_q};
  assign mepc_o         = mepc_q;
  assign mie_o          = mie_q;
  assign m_irq_enable_o = mstatus_mie_q;

  // Controller never enters and leaves a trap in one cycle
  assert property (@(posedge clk) disable iff (!rst_n) !(trap_save_i && mret_i))
    else $error("trap_save_i and mret_i high together");

endmodule

`default_nettype wire

//--- hpm/hpm_counters.sv
// Cycle, instret and event counters with event select and inhibit
`timescale 1ns/1ns
`default_nettype none
`include "csr_params.svh"

module hpm_counters import csr_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst_n,
  // Software access
  input  wire csr_addr_t csr_addr_i,
  input  wire logic      csr_we_i,
  input  wire csr_word_t csr_wdata_i,
  // Event pulses from the pipeline
  input  wire logic      event_instret_i,
  input  wire logic      event_load_i,
  input  wire logic      event_store_i,
  input  wire logic      event_branch_i,
  // Read side
  output csr_word_t      rdata_o,
  output logic           hit_o
);

  localparam int NUM_CNT = 3;   // 0 mcycle, 1 minstret, 2 mhpmcounter3

  hpm_count_t           cnt_q [NUM_CNT];
  csr_word_t            inhibit_q;        // mcountinhibit
  hpm_event_t           evt_sel_q;        // mhpmevent3
  hpm_event_t           events;
  logic [NUM_CNT-1:0]   wr_lo;
  logic [NUM_CNT-1:0]   wr_hi;
  logic [NUM_CNT-1:0]   cnt_inh;
  logic [NUM_CNT-1:0]   cnt_inc;

  ////////////////////////////////////////
  // Event lines
  ////////////////////////////////////////

  always_comb begin
    events                     = '0;
    events[`HPM_EVENT_CYCLE]   = 1'b1;          // Every cycle
    events[`HPM_EVENT_INSTRET] = event_instret_i;
    events[`HPM_EVENT_LOAD]    = event_load_i;
    events[`HPM_EVENT_STORE]   = event_store_i;
    events[`HPM_EVENT_BRANCH]  = event_branch_i;
  end

  // Inhibit bits CY, IR and HPM3
  assign cnt_inh = {inhibit_q[3], inhibit_q[2], inhibit_q[0]};

  // Raw count conditions, gated by inhibit
  assign cnt_inc = ~cnt_inh & {|(events & evt_sel_q), event_instret_i, 1'b1};

  // Half write strobes
  assign wr_lo[0] = csr_we_i && (csr_addr_i == `CSR_ADDR_MCYCLE);
  assign wr_lo[1] = csr_we_i && (csr_addr_i == `CSR_ADDR_MINSTRET);
  assign wr_lo[2] = csr_we_i && (csr_addr_i == `CSR_ADDR_MHPMCOUNTER3);
  assign wr_hi[0] = csr_we_i && (csr_addr_i == `CSR_ADDR_MCYCLEH);
  assign wr_hi[1] = csr_we_i && (csr_addr_i == `CSR_ADDR_MINSTRETH);
  assign wr_hi[2] = csr_we_i && (csr_addr_i == `CSR_ADDR_MHPMCOUNTER3H);

  ////////////////////////////////////////
  // Counter registers
  ////////////////////////////////////////

  for (genvar i = 0; i < NUM_CNT; i++) begin : gen_cnt
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q[i] <= '0;
      end else if (wr_lo[i]) begin
        cnt_q[i][31:0] <= csr_wdata_i;          // Write wins, no count
      end else if (wr_hi[i]) begin
        cnt_q[i][63:32] <= csr_wdata_i;
      end else if (cnt_inc[i]) begin
        cnt_q[i] <= cnt_q[i] + 64'd1;
      end
    end

    // A stopped counter only moves through a software write
    assert property (@(posedge clk) disable iff (!rst_n)
                     (cnt_inh[i] && !wr_lo[i] && !wr_hi[i]) |=> $stable(cnt_q[i]))
      else $error("inhibited counter %0d changed", i);
  end

  // Control registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inhibit_q <= `MCOUNTINHIBIT_RESET_VAL;   // Stopped out of reset
      evt_sel_q <= '0;
    end else if (csr_we_i) begin
      if (csr_addr_i == `CSR_ADDR_MCOUNTINHIBIT) inhibit_q <= csr_wdata_i & `MCOUNTINHIBIT_MASK;
      if (csr_addr_i == `CSR_ADDR_MHPMEVENT3)    evt_sel_q <= csr_wdata_i[4:0];
    end
  end

  ////////////////////////////////////////
  // Read decode
  ////////////////////////////////////////

  always_comb begin
    hit_o   = 1'b1;
    rdata_o = '0;
    case (csr_addr_i)
      `CSR_ADDR_MCYCLE:        rdata_o = cnt_q[0][31:0];
      `CSR_ADDR_MCYCLEH:       rdata_o = cnt_q[0][63:32];
      `CSR_ADDR_MINSTRET:      rdata_o = cnt_q[1][31:0];
      `CSR_ADDR_MINSTRETH:     rdata_o = cnt_q[1][63:32];
      `CSR_ADDR_MHPMCOUNTER3:  rdata_o = cnt_q[2][31:0];
      `CSR_ADDR_MHPMCOUNTER3H: rdata_o = cnt_q[2][63:32];
      `CSR_ADDR_MCOUNTINHIBIT: rdata_o = inhibit_q;
      `CSR_ADDR_MHPMEVENT3:    rdata_o = {27'b0, evt_sel_q};
      default:                 hit_o   = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/csr_file_top.sv
// Machine CSR file top with access unit, trap bank and counter bank
`timescale 1ns/1ns
`default_nettype none

module csr_file_top import csr_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst_n,
  // CSR access port
  input  wire logic        csr_access_i,
  input  wire csr_addr_t   csr_addr_i,
  input  wire csr_op_e     csr_op_i,
  input  wire csr_word_t   csr_wdata_i,
  output csr_word_t        csr_rdata_o,
  // Trap controller
  input  wire logic        trap_save_i,
  input  wire logic [5:0]  trap_cause_i,
  input  wire csr_word_t   trap_pc_i,
  input  wire logic        mret_i,
  input  wire csr_word_t   mip_i,
  // Performance events
  input  wire logic        event_instret_i,
  input  wire logic        event_load_i,
  input  wire logic        event_store_i,
  input  wire logic        event_branch_i,
  // Trap state to the core
  output logic [23:0]      mtvec_addr_o,
  output logic [1:0]       mtvec_mode_o,
  output csr_word_t        mepc_o,
  output csr_word_t        mie_o,
  output logic             m_irq_enable_o
);

  logic      trap_hit;
  csr_word_t trap_rdata;
  logic      hpm_hit;
  csr_word_t hpm_rdata;
  logic      csr_we;          // Broadcast to both banks
  csr_word_t csr_new_wdata;

  csr_access_unit u_access (
    .csr_access_i    (csr_access_i),
    .csr_op_i        (csr_op_i),
    .csr_wdata_i     (csr_wdata_i),
    .trap_hit_i      (trap_hit),
    .trap_rdata_i    (trap_rdata),
    .hpm_hit_i       (hpm_hit),
    .hpm_rdata_i     (hpm_rdata),
    .csr_rdata_o     (csr_rdata_o),
    .csr_we_o        (csr_we),
    .csr_new_wdata_o (csr_new_wdata)
  );

  machine_trap_csrs u_trap (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_addr_i     (csr_addr_i),
    .csr_we_i       (csr_we),
    .csr_wdata_i    (csr_new_wdata),
    .trap_save_i    (trap_save_i),
    .trap_cause_i   (trap_cause_i),
    .trap_pc_i      (trap_pc_i),
    .mret_i         (mret_i),
    .mip_i          (mip_i),
    .rdata_o        (trap_rdata),
    .hit_o          (trap_hit),
    .mtvec_addr_o   (mtvec_addr_o),
    .mtvec_mode_o   (mtvec_mode_o),
    .mepc_o         (mepc_o),
    .mie_o          (mie_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  hpm_counters u_hpm (
    .clk             (clk),
    .rst_n           (rst_n),
    .csr_addr_i      (csr_addr_i),
    .csr_we_i        (csr_we),
    .csr_wdata_i     (csr_new_wdata),
    .event_instret_i (event_instret_i),
    .event_load_i    (event_load_i),
    .event_store_i   (event_store_i),
    .event_branch_i  (event_branch_i),
    .rdata_o         (hpm_rdata),
    .hit_o           (hpm_hit)
  );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,  // 20 ns period
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset held low over the first rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;                // Released on an edge, like the stimulus
  end

endmodule

`default_nettype wire

//--- sim/tb_csr_file.sv
// Stimulus, shadow register model and checker for the machine CSR file
`timescale 1ns/1ns
`default_nettype none
`include "csr_params.svh"

module tb_csr_file import csr_pkg::*; ();

  localparam int unsigned SEED          = 32'h0775e8c3;
  localparam int          RESET_TIMEOUT = 50;      // Cycles
  localparam int          RUN_TIMEOUT   = 20000;

  logic        clk;
  logic        rst_n;
  logic        csr_access;
  csr_addr_t   csr_addr;
  csr_op_e     csr_op;
  csr_word_t   csr_wdata;
  csr_word_t   csr_rdata;
  logic        trap_save;
  logic [5:0]  trap_cause;
  csr_word_t   trap_pc;
  logic        mret;
  csr_word_t   mip;
  logic        ev_instret, ev_load, ev_store, ev_branch;
  logic [23:0] mtvec_addr;
  logic [1:0]  mtvec_mode;
  csr_word_t   mepc;
  csr_word_t   mie;
  logic        m_irq_enable;

  // Shadow registers of the model
  logic        sh_mie_bit;
  logic        sh_mpie_bit;
  csr_word_t   sh_mie, sh_mtvec, sh_mscratch, sh_mepc, sh_mcause;
  csr_word_t   sh_inhibit, sh_evtsel;
  hpm_count_t  sh_cnt [3];          // mcycle, minstret, mhpmcounter3
  csr_word_t   exp_rdata;
  csr_word_t   last_rdata;          // Read data of the last driven cycle
  logic        rand_events;

  tb_clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(3)) u_clk (.clk_o(clk), .rst_n_o(rst_n));

  csr_file_top dut0 (
    .clk(clk), .rst_n(rst_n),
    .csr_access_i(csr_access), .csr_addr_i(csr_addr), .csr_op_i(csr_op),
    .csr_wdata_i(csr_wdata), .csr_rdata_o(csr_rdata),
    .trap_save_i(trap_save), .trap_cause_i(trap_cause), .trap_pc_i(trap_pc),
    .mret_i(mret), .mip_i(mip),
    .event_instret_i(ev_instret), .event_load_i(ev_load),
    .event_store_i(ev_store), .event_branch_i(ev_branch),
    .mtvec_addr_o(mtvec_addr), .mtvec_mode_o(mtvec_mode),
    .mepc_o(mepc), .mie_o(mie), .m_irq_enable_o(m_irq_enable)
  );

  ////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////

  task automatic end_in_failure();
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic report_mismatch(input string name, input csr_word_t got, input csr_word_t exp);
    $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end_in_failure();
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic csr_word_t csr_model_read(input csr_addr_t a);
    case (a)
      `CSR_ADDR_MSTATUS:       return {19'b0, 2'b11, 3'b0, sh_mpie_bit, 3'b0, sh_mie_bit, 3'b0};
      `CSR_ADDR_MISA:          return `MISA_VALUE;
      `CSR_ADDR_MIE:           return sh_mie;
      `CSR_ADDR_MTVEC:         return sh_mtvec;
      `CSR_ADDR_MSCRATCH:      return sh_mscratch;
      `CSR_ADDR_MEPC:          return sh_mepc;
      `CSR_ADDR_MCAUSE:        return sh_mcause;
      `CSR_ADDR_MIP:           return mip;              // Live input
      `CSR_ADDR_MVENDORID:     return `MVENDORID_VALUE;
      `CSR_ADDR_MARCHID:       return `MARCHID_VALUE;
      `CSR_ADDR_MCOUNTINHIBIT: return sh_inhibit;
      `CSR_ADDR_MHPMEVENT3:    return sh_evtsel;
      `CSR_ADDR_MCYCLE:        return sh_cnt[0][31:0];
      `CSR_ADDR_MCYCLEH:       return sh_cnt[0][63:32];
      `CSR_ADDR_MINSTRET:      return sh_cnt[1][31:0];
      `CSR_ADDR_MINSTRETH:     return sh_cnt[1][63:32];
      `CSR_ADDR_MHPMCOUNTER3:  return sh_cnt[2][31:0];
      `CSR_ADDR_MHPMCOUNTER3H: return sh_cnt[2][63:32];
      default:                 return '0;               // Unmapped
    endcase
  endfunction

  function automatic logic csr_model_mapped(input csr_addr_t a);
    case (a)
      `CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC,
      `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MIP,
      `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MCOUNTINHIBIT,
      `CSR_ADDR_MHPMEVENT3, `CSR_ADDR_MCYCLE, `CSR_ADDR_MCYCLEH,
      `CSR_ADDR_MINSTRET, `CSR_ADDR_MINSTRETH, `CSR_ADDR_MHPMCOUNTER3,
      `CSR_ADDR_MHPMCOUNTER3H: return 1'b1;
      default:                 return 1'b0;
    endcase
  endfunction

  // Half writes beat the increment
  function automatic hpm_count_t next_count(input hpm_count_t c, input logic wr_lo,
                                            input logic wr_hi, input logic inc,
                                            input csr_word_t nv);
    if (wr_lo) return {c[63:32], nv};
    if (wr_hi) return {nv, c[31:0]};
    if (inc)   return c + 64'd1;
    return c;
  endfunction

  task automatic model_reset();
    sh_mie_bit  = 1'b0;
    sh_mpie_bit = 1'b0;
    sh_mie      = '0;
    sh_mtvec    = `MTVEC_RESET_VAL;
    sh_mscratch = '0;
    sh_mepc     = '0;
    sh_mcause   = '0;
    sh_inhibit  = `MCOUNTINHIBIT_RESET_VAL;
    sh_evtsel   = '0;
    for (int i = 0; i < 3; i++) sh_cnt[i] = '0;
  endtask

  // Next state from the inputs that the coming edge samples
  task automatic model_step();
    csr_word_t  cur;
    csr_word_t  nv;
    logic       we;
    hpm_event_t ev;
    logic [2:0] inc;
    cur = csr_model_read(csr_addr);
    we  = csr_access && (csr_op != CSR_OP_READ) && csr_model_mapped(csr_addr);
    case (csr_op)
      CSR_OP_WRITE: nv = csr_wdata;
      CSR_OP_SET:   nv = cur | csr_wdata;
      CSR_OP_CLEAR: nv = cur & ~csr_wdata;
      default:      nv = cur;
    endcase
    ev                     = '0;
    ev[`HPM_EVENT_CYCLE]   = 1'b1;
    ev[`HPM_EVENT_INSTRET] = ev_instret;
    ev[`HPM_EVENT_LOAD]    = ev_load;
    ev[`HPM_EVENT_STORE]   = ev_store;
    ev[`HPM_EVENT_BRANCH]  = ev_branch;
    inc[0] = !sh_inhibit[0];                          // Old inhibit value
    inc[1] = !sh_inhibit[2] && ev_instret;
    inc[2] = !sh_inhibit[3] && (|(ev & sh_evtsel[4:0]));
    sh_cnt[0] = next_count(sh_cnt[0], we && csr_addr == `CSR_ADDR_MCYCLE,
                           we && csr_addr == `CSR_ADDR_MCYCLEH, inc[0], nv);
    sh_cnt[1] = next_count(sh_cnt[1], we && csr_addr == `CSR_ADDR_MINSTRET,
                           we && csr_addr == `CSR_ADDR_MINSTRETH, inc[1], nv);
    sh_cnt[2] = next_count(sh_cnt[2], we && csr_addr == `CSR_ADDR_MHPMCOUNTER3,
                           we && csr_addr == `CSR_ADDR_MHPMCOUNTER3H, inc[2], nv);
    if (trap_save) begin                              // Trap entry wins
      sh_mpie_bit = sh_mie_bit;
      sh_mie_bit  = 1'b0;
      sh_mepc     = trap_pc;
      sh_mcause   = {trap_cause[5], 26'b0, trap_cause[4:0]};
    end else begin
      if (mret) begin
        sh_mie_bit  = sh_mpie_bit;
        sh_mpie_bit = 1'b1;
      end else if (we && csr_addr == `CSR_ADDR_MSTATUS) begin
        sh_mie_bit  = nv[`MSTATUS_MIE_BIT];
        sh_mpie_bit = nv[`MSTATUS_MPIE_BIT];
      end
      if (we && csr_addr == `CSR_ADDR_MEPC)   sh_mepc   = nv & ~32'h1;
      if (we && csr_addr == `CSR_ADDR_MCAUSE) sh_mcause = nv & 32'h8000001F;
    end
    if (we) begin
      case (csr_addr)
        `CSR_ADDR_MIE:           sh_mie      = nv & `MIE_WRITE_MASK;
        `CSR_ADDR_MTVEC:         sh_mtvec    = nv & 32'hFFFFFF01;
        `CSR_ADDR_MSCRATCH:      sh_mscratch = nv;
        `CSR_ADDR_MCOUNTINHIBIT: sh_inhibit  = nv & `MCOUNTINHIBIT_MASK;
        `CSR_ADDR_MHPMEVENT3:    sh_evtsel   = nv & 32'h1F;
        default: ;                                    // Read only or counter
      endcase
    end
  endtask

  ////////////////////////////////////////
  // Compare process, mid cycle
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      model_reset();
    end else begin
      exp_rdata = csr_access ? csr_model_read(csr_addr) : '0;
      assert (csr_rdata == exp_rdata) else report_mismatch("csr_rdata_o", csr_rdata, exp_rdata);
      assert (m_irq_enable == sh_mie_bit)
        else report_mismatch("m_irq_enable_o", {31'b0, m_irq_enable}, {31'b0, sh_mie_bit});
      assert (mepc == sh_mepc) else report_mismatch("mepc_o", mepc, sh_mepc);
      assert (mie == sh_mie) else report_mismatch("mie_o", mie, sh_mie);
      assert ({mtvec_addr, 6'b0, mtvec_mode} == sh_mtvec)
        else report_mismatch("mtvec_addr_o/mtvec_mode_o", {mtvec_addr, 6'b0, mtvec_mode}, sh_mtvec);
      model_step();
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // One cycle of inputs, read data sampled mid cycle
  task automatic do_cycle(input logic acc, input csr_op_e op, input csr_addr_t addr,
                          input csr_word_t wdata, input logic save, input logic ret);
    @(posedge clk);
    csr_access <= acc;
    csr_op     <= op;
    csr_addr   <= addr;
    csr_wdata  <= wdata;
    trap_save  <= save;
    mret       <= ret;
    trap_cause <= 6'($urandom);
    trap_pc    <= $urandom;
    mip        <= $urandom;
    {ev_branch, ev_store, ev_load, ev_instret} <= rand_events ? 4'($urandom) : 4'b0;
    @(negedge clk);
    last_rdata = csr_rdata;
  endtask

  // Strobe low on a mapped CSR, so no read data and no write
  task automatic idle(input int n);
    repeat (n) do_cycle(1'b0, CSR_OP_WRITE, `CSR_ADDR_MSTATUS, $urandom, 1'b0, 1'b0);
  endtask

  task automatic read_expect(input csr_addr_t addr, input csr_word_t exp, input string name);
    do_cycle(1'b1, CSR_OP_READ, addr, '0, 1'b0, 1'b0);
    assert (last_rdata == exp) else report_mismatch(name, last_rdata, exp);
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (!rst_n) begin
      @(posedge clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) begin
        $display("Timeout: reset was not released after %0d cycles", RESET_TIMEOUT);
        end_in_failure();
      end
    end
  endtask

  initial begin : run_watchdog
    repeat (RUN_TIMEOUT) @(posedge clk);
    $display("Timeout: stimulus still running after %0d cycles", RUN_TIMEOUT);
    end_in_failure();
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin : stimulus
    csr_addr_t trap_addrs [14];
    csr_addr_t addr;
    csr_word_t v;
    csr_word_t frozen;
    int        k;
    trap_addrs = '{`CSR_ADDR_MSTATUS, `CSR_ADDR_MISA, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC,
                   `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MIP,
                   `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID,
                   12'h302, 12'h7C0, 12'h000, 12'hFFF};   // Last four unmapped
    csr_access  = 1'b0;
    csr_addr    = '0;
    csr_op      = CSR_OP_READ;
    csr_wdata   = '0;
    trap_save   = 1'b0;
    trap_cause  = '0;
    trap_pc     = '0;
    mret        = 1'b0;
    mip         = '0;
    {ev_branch, ev_store, ev_load, ev_instret} = 4'b0;
    rand_events = 1'b0;
    void'($urandom(SEED));
    wait_reset_release();

    // Reset values
    read_expect(`CSR_ADDR_MSTATUS, 32'h1800, "csr_rdata_o(mstatus)");
    read_expect(`CSR_ADDR_MTVEC, `MTVEC_RESET_VAL, "csr_rdata_o(mtvec)");
    read_expect(`CSR_ADDR_MCOUNTINHIBIT, 32'hD, "csr_rdata_o(mcountinhibit)");
    read_expect(`CSR_ADDR_MISA, `MISA_VALUE, "csr_rdata_o(misa)");
    read_expect(`CSR_ADDR_MVENDORID, `MVENDORID_VALUE, "csr_rdata_o(mvendorid)");
    read_expect(`CSR_ADDR_MARCHID, `MARCHID_VALUE, "csr_rdata_o(marchid)");
    assert (m_irq_enable == 1'b0)
      else report_mismatch("m_irq_enable_o", {31'b0, m_irq_enable}, 32'd0);

    // Random access mix on the trap bank, each op followed by a read back
    for (int i = 0; i < 300; i++) begin
      addr = trap_addrs[$urandom_range(0, 13)];
      do_cycle(1'b1, csr_op_e'($urandom_range(0, 3)), addr, $urandom, 1'b0, 1'b0);
      do_cycle(1'b1, CSR_OP_READ, addr, '0, 1'b0, 1'b0);
    end

    // Trap entry and return with known values
    do_cycle(1'b1, CSR_OP_WRITE, `CSR_ADDR_MSTATUS, 32'h8, 1'b0, 1'b0);
    do_cycle(1'b0, CSR_OP_READ, '0, '0, 1'b1, 1'b0);
    read_expect(`CSR_ADDR_MSTATUS, 32'h1880, "csr_rdata_o(mstatus)");
    do_cycle(1'b0, CSR_OP_READ, '0, '0, 1'b0, 1'b1);
    read_expect(`CSR_ADDR_MSTATUS, 32'h1888, "csr_rdata_o(mstatus)");

    // Random traps and mret, software writes in the same cycle
    for (int i = 0; i < 100; i++) begin
      addr = trap_addrs[$urandom_range(0, 6)];
      case ($urandom_range(0, 3))
        0:       do_cycle(1'b1, csr_op_e'($urandom_range(1, 3)), addr, $urandom, 1'b1, 1'b0);
        1:       do_cycle(1'b1, CSR_OP_WRITE, addr, $urandom, 1'b0, 1'b1);
        2:       do_cycle(1'b1, CSR_OP_WRITE, `CSR_ADDR_MSTATUS, $urandom, 1'b0, 1'b0);
        default: idle(1);
      endcase
      do_cycle(1'b1, CSR_OP_READ, `CSR_ADDR_MSTATUS, '0, 1'b0, 1'b0);
      do_cycle(1'b1, CSR_OP_READ, `CSR_ADDR_MEPC, '0, 1'b0, 1'b0);
      do_cycle(1'b1, CSR_OP_READ, `CSR_ADDR_MCAUSE, '0, 1'b0, 1'b0);
    end

    // mcycle runs V, V+1, ... once enabled
    do_cycle(1'b1, CSR_OP_CLEAR, `CSR_ADDR_MCOUNTINHIBIT, 32'h1, 1'b0, 1'b0);
    for (int i = 0; i < 5; i++) begin
      v = $urandom & 32'h7FFFFFFF;
      k = $urandom_range(1, 40);
      do_cycle(1'b1, CSR_OP_WRITE, `CSR_ADDR_MCYCLE, v, 1'b0, 1'b0);
      idle(k);
      read_expect(`CSR_ADDR_MCYCLE, v + k, "csr_rdata_o(mcycle)");
    end
    v = $urandom & 32'h7FFFFFFF;                      // High half, no wrap
    do_cycle(1'b1, CSR_OP_WRITE, `CSR_ADDR_MCYCLEH, v, 1'b0, 1'b0);
    do_cycle(1'b1, CSR_OP_WRITE, `CSR_ADDR_MCYCLE, 32'hFFFFFFF0, 1'b0, 1'b0);
    idle(20);
    read_expect(`CSR_ADDR_MCYCLEH, v + 1, "csr_rdata_o(mcycleh)");

    // Event counters under random event traffic
    rand_events = 1'b1;
    v = ($urandom & ~32'h1F) | (32'($urandom_range(1, 15)) << 1);  // Some event, not cycle
    do_cycle(1'b1, CSR_OP_WRITE, `CSR_ADDR_MHPMEVENT3, v, 1'b0, 1'b0);
    do_cycle(1'b1, CSR_OP_CLEAR, `CSR_ADDR_MCOUNTINHIBIT, 32'hC, 1'b0, 1'b0);
    for (int i = 0; i < 200; i++) begin
      case ($urandom_range(0, 4))
        0:       do_cycle(1'b1, CSR_OP_READ, `CSR_ADDR_MINSTRET, '0, 1'b0, 1'b0);
        1:       do_cycle(1'b1, CSR_OP_READ, `CSR_ADDR_MINSTRETH, '0, 1'b0, 1'b0);
        2:       do_cycle(1'b1, CSR_OP_READ, `CSR_ADDR_MHPMCOUNTER3, '0, 1'b0, 1'b0);
        3:       do_cycle(1'b1, CSR_OP_READ, `CSR_ADDR_MHPMCOUNTER3H, '0, 1'b0, 1'b0);
        default: idle(1);
      endcase
    end

    // Inhibit freezes minstret, then mhpmcounter3
    do_cycle(1'b1, CSR_OP_SET, `CSR_ADDR_MCOUNTINHIBIT, 32'h4, 1'b0, 1'b0);
    do_cycle(1'b1, CSR_OP_READ, `CSR_ADDR_MINSTRET, '0, 1'b0, 1'b0);
    frozen = sh_cnt[1][31:0];                         // Model count, now stopped
    idle(30);
    read_expect(`CSR_ADDR_MINSTRET, frozen, "csr_rdata_o(minstret)");
    do_cycle(1'b1, CSR_OP_SET, `CSR_ADDR_MCOUNTINHIBIT, 32'h8, 1'b0, 1'b0);
    do_cycle(1'b1, CSR_OP_READ, `CSR_ADDR_MHPMCOUNTER3, '0, 1'b0, 1'b0);
    frozen = sh_cnt[2][31:0];
    idle(30);
    read_expect(`CSR_ADDR_MHPMCOUNTER3, frozen, "csr_rdata_o(mhpmcounter3)");

    rand_events = 1'b0;
    idle(2);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/csr_pkg.sv
verilog/csr_access_unit.sv
trap/machine_trap_csrs.sv
hpm/hpm_counters.sv
verilog/csr_file_top.sv
sim/tb_clock_gen.sv
sim/tb_csr_file.sv

//--- run_sim.sh
#!/bin/sh
# Build the CSR file testbench with Verilator and run it
# Exit status is the simulation's own status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_csr_file \
  -Mdir obj_dir \
  -f sources.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_csr_file
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished"
exit 0
